/* verilog/pipe_isa_pkg.sv */
/*
 * Instruction-set definitions for the integer pipeline slice.
 * Data and register-file sizes, the internal operation codes, and
 * field positions and major opcodes of the 3R, 2RI12 and 1RI20 formats.
 */
package pipe_isa_pkg;

  localparam int XLEN    = 32;
  localparam int REG_NUM = 32;

  typedef logic [$clog2(REG_NUM)-1:0] reg_idx_t;

  // Internal operation, independent of the encoding
  typedef enum logic [3:0] {
    OP_INVALID,
    OP_ADD_W,
    OP_SUB_W,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL_W,
    OP_SRL_W,
    OP_SLT,
    OP_ADDI_W,
    OP_LU12I_W
  } opcode_e;

  // ====================
  // Field positions
  localparam int RD_LSB   = 0;
  localparam int RJ_LSB   = 5;
  localparam int RK_LSB   = 10;
  localparam int SI12_LSB = 10;
  localparam int SI20_LSB = 5;

  // Major opcode sits in the top bits, width depends on format
  localparam int OPC_3R_LSB    = 15;
  localparam int OPC_2RI12_LSB = 22;
  localparam int OPC_1RI20_LSB = 25;

  // ====================
  // Major opcodes
  localparam logic [16:0] OPC_ADD_W   = 17'h00020;
  localparam logic [16:0] OPC_SUB_W   = 17'h00022;
  localparam logic [16:0] OPC_SLT     = 17'h00024;
  localparam logic [16:0] OPC_AND     = 17'h00029;
  localparam logic [16:0] OPC_OR      = 17'h0002A;
  localparam logic [16:0] OPC_XOR     = 17'h0002B;
  localparam logic [16:0] OPC_SLL_W   = 17'h0002E;
  localparam logic [16:0] OPC_SRL_W   = 17'h0002F;
  localparam logic [9:0]  OPC_ADDI_W  = 10'h00A;
  localparam logic [6:0]  OPC_LU12I_W = 7'h0A;

endpackage : pipe_isa_pkg

/* verilog/pipe_stage_pkg.sv */
/*
 * Stage records of the integer pipeline slice.
 * Packed structs carried from the instruction slot to decode,
 * from decode to execute, and from execute to write-back and retire.
 */
package pipe_stage_pkg;

  // Instruction slot, filled by the four-phase receiver
  typedef struct packed {
    logic        valid;
    logic [31:0] inst;
  } slot_st;

  // Decoded op with operands already resolved
  typedef struct packed {
    logic                              valid;
    pipe_isa_pkg::opcode_e             op;
    pipe_isa_pkg::reg_idx_t            rd;
    logic [pipe_isa_pkg::XLEN-1:0]     opnd_a;
    // Immediate forms carry the extended immediate here
    logic [pipe_isa_pkg::XLEN-1:0]     opnd_b;
    logic                              we;
  } decoded_st;

  // Execute result, also the shape of the retire port
  typedef struct packed {
    logic                              valid;
    pipe_isa_pkg::reg_idx_t            rd;
    logic [pipe_isa_pkg::XLEN-1:0]     value;
    logic                              we;
  } result_st;

endpackage : pipe_stage_pkg

/* verilog/inst_accept.sv */
/*
 * Instruction receiver.
 * Four-phase req/ack sink that latches one instruction word into
 * the slot and presents it to decode for a single cycle.
 */
`timescale 1ns/100ps

module inst_accept (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   inst_req_i,
  input  logic [31:0]            inst_i,
  output logic                   inst_ack_o,
  output pipe_stage_pkg::slot_st slot_o
);

  typedef enum logic {
    IDLE,
    ACKED
  } hs_state_e;

  hs_state_e state_q;
  hs_state_e state_d;
  logic      accept;

  // Accepting edge: req up while ack still down
  assign accept = (state_q == IDLE) && inst_req_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (inst_req_i) state_d = ACKED;
      // Wait for the source to drop req
      ACKED:   if (!inst_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign inst_ack_o = (state_q == ACKED);

  // Slot valid is a one-cycle pulse after the accepting edge
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_o <= '0;
    end else begin
      slot_o.valid <= accept;
      if (accept) begin
        slot_o.inst <= inst_i;
      end
    end
  end

endmodule : inst_accept

/* verilog/inst_decoder.sv */
/*
 * Decode stage.
 * Splits the slot word into fields, maps the major opcode, reads the
 * register file with forwarding from execute and registers the op.
 */
`timescale 1ns/100ps

module inst_decoder (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  pipe_stage_pkg::slot_st              slot_i,
  output pipe_isa_pkg::reg_idx_t              rs1_o,
  output pipe_isa_pkg::reg_idx_t              rs2_o,
  input  logic [pipe_isa_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [pipe_isa_pkg::XLEN-1:0]       rs2_data_i,
  input  pipe_stage_pkg::result_st            fwd_i,
  output pipe_stage_pkg::decoded_st           dec_o
);

  logic [31:0]                   inst;
  pipe_isa_pkg::reg_idx_t        rd;
  pipe_isa_pkg::opcode_e         op;
  logic [pipe_isa_pkg::XLEN-1:0] rj_val;
  logic [pipe_isa_pkg::XLEN-1:0] rk_val;
  logic [pipe_isa_pkg::XLEN-1:0] imm12;
  logic [pipe_isa_pkg::XLEN-1:0] imm20;
  pipe_stage_pkg::decoded_st     dec_d;

  // Execute result wins over the register file on a live rd match
  function automatic logic [pipe_isa_pkg::XLEN-1:0] fwd_sel(
    input pipe_isa_pkg::reg_idx_t        idx,
    input logic [pipe_isa_pkg::XLEN-1:0] rf_val,
    input pipe_stage_pkg::result_st      fwd
  );
    if (fwd.valid && fwd.we && (fwd.rd == idx) && (idx != '0)) begin
      return fwd.value;
    end
    return rf_val;
  endfunction

  // ====================
  // Field extraction
  assign inst  = slot_i.inst;
  assign rd    = inst[pipe_isa_pkg::RD_LSB +: 5];
  assign rs1_o = inst[pipe_isa_pkg::RJ_LSB +: 5];
  assign rs2_o = inst[pipe_isa_pkg::RK_LSB +: 5];
  assign imm12 = {{20{inst[pipe_isa_pkg::SI12_LSB + 11]}}, inst[pipe_isa_pkg::SI12_LSB +: 12]};
  assign imm20 = {inst[pipe_isa_pkg::SI20_LSB +: 20], 12'b0};

  always_comb begin
    op = pipe_isa_pkg::OP_INVALID;
    if (inst[pipe_isa_pkg::OPC_1RI20_LSB +: 7] == pipe_isa_pkg::OPC_LU12I_W) begin
      op = pipe_isa_pkg::OP_LU12I_W;
    end else if (inst[pipe_isa_pkg::OPC_2RI12_LSB +: 10] == pipe_isa_pkg::OPC_ADDI_W) begin
      op = pipe_isa_pkg::OP_ADDI_W;
    end else begin
      case (inst[pipe_isa_pkg::OPC_3R_LSB +: 17])
        pipe_isa_pkg::OPC_ADD_W: op = pipe_isa_pkg::OP_ADD_W;
        pipe_isa_pkg::OPC_SUB_W: op = pipe_isa_pkg::OP_SUB_W;
        pipe_isa_pkg::OPC_SLT:   op = pipe_isa_pkg::OP_SLT;
        pipe_isa_pkg::OPC_AND:   op = pipe_isa_pkg::OP_AND;
        pipe_isa_pkg::OPC_OR:    op = pipe_isa_pkg::OP_OR;
        pipe_isa_pkg::OPC_XOR:   op = pipe_isa_pkg::OP_XOR;
        pipe_isa_pkg::OPC_SLL_W: op = pipe_isa_pkg::OP_SLL_W;
        pipe_isa_pkg::OPC_SRL_W: op = pipe_isa_pkg::OP_SRL_W;
        default:                 op = pipe_isa_pkg::OP_INVALID;
      endcase
    end
  end

  // ====================
  // Operand select
  assign rj_val = fwd_sel(rs1_o, rs1_data_i, fwd_i);
  assign rk_val = fwd_sel(rs2_o, rs2_data_i, fwd_i);

  always_comb begin
    dec_d.valid  = slot_i.valid;
    dec_d.op     = op;
    dec_d.rd     = rd;
    dec_d.opnd_a = rj_val;
    case (op)
      pipe_isa_pkg::OP_ADDI_W:  dec_d.opnd_b = imm12;
      pipe_isa_pkg::OP_LU12I_W: dec_d.opnd_b = imm20;
      default:                  dec_d.opnd_b = rk_val;
    endcase
    // No write to r0 and none for an undecodable word
    dec_d.we = (rd != '0) && (op != pipe_isa_pkg::OP_INVALID);
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_o <= '0;
    end else begin
      dec_o <= dec_d;
    end
  end

endmodule : inst_decoder

/* verilog/int_execute.sv */
/*
 * Integer execute stage.
 * 32-bit ALU for the three-register and immediate operations,
 * result registered together with rd and write enable.
 */
`timescale 1ns/100ps

module int_execute (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  pipe_stage_pkg::decoded_st dec_i,
  output pipe_stage_pkg::result_st  res_o
);

  logic [pipe_isa_pkg::XLEN-1:0] opnd_a;
  logic [pipe_isa_pkg::XLEN-1:0] opnd_b;
  logic [4:0]                    shamt;
  logic                          a_lt_b;
  logic [pipe_isa_pkg::XLEN-1:0] alu_out;

  assign opnd_a = dec_i.opnd_a;
  assign opnd_b = dec_i.opnd_b;

  // Only the low 5 bits of b count for shifts
  assign shamt  = opnd_b[4:0];
  assign a_lt_b = $signed(opnd_a) < $signed(opnd_b);

  // ====================
  // ALU
  always_comb begin
    case (dec_i.op)
      pipe_isa_pkg::OP_ADD_W,
      pipe_isa_pkg::OP_ADDI_W:  alu_out = opnd_a + opnd_b;
      pipe_isa_pkg::OP_SUB_W:   alu_out = opnd_a - opnd_b;
      pipe_isa_pkg::OP_AND:     alu_out = opnd_a & opnd_b;
      pipe_isa_pkg::OP_OR:      alu_out = opnd_a | opnd_b;
      pipe_isa_pkg::OP_XOR:     alu_out = opnd_a ^ opnd_b;
      pipe_isa_pkg::OP_SLL_W:   alu_out = opnd_a << shamt;
      pipe_isa_pkg::OP_SRL_W:   alu_out = opnd_a >> shamt;
      pipe_isa_pkg::OP_SLT:     alu_out = {{(pipe_isa_pkg::XLEN - 1){1'b0}}, a_lt_b};
      // b already holds si20 << 12
      pipe_isa_pkg::OP_LU12I_W: alu_out = opnd_b;
      default:                  alu_out = '0;
    endcase
  end

  // ====================
  // Result register, also the forwarding source for decode
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_o <= '0;
    end else begin
      res_o.valid <= dec_i.valid;
      res_o.rd    <= dec_i.rd;
      res_o.value <= alu_out;
      res_o.we    <= dec_i.we;
    end
  end

endmodule : int_execute

/* verilog/reg_writeback.sv */
/*
 * Write-back and retire.
 * 31 writable architectural registers with r0 tied to zero,
 * two combinational read ports and the registered retire port.
 */
`timescale 1ns/100ps

module reg_writeback (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  pipe_stage_pkg::result_st      res_i,
  input  pipe_isa_pkg::reg_idx_t        rs1_i,
  input  pipe_isa_pkg::reg_idx_t        rs2_i,
  output logic [pipe_isa_pkg::XLEN-1:0] rs1_data_o,
  output logic [pipe_isa_pkg::XLEN-1:0] rs2_data_o,
  output pipe_stage_pkg::result_st      retire_o
);

  // Entry 0 does not exist, reads of r0 return zero
  logic [pipe_isa_pkg::XLEN-1:0] regs [1:pipe_isa_pkg::REG_NUM-1];
  logic                          wr_en;

  assign wr_en = res_i.valid && res_i.we && (res_i.rd != '0);

  // ====================
  // Register file
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < pipe_isa_pkg::REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[res_i.rd] <= res_i.value;
    end
  end

  always_comb begin
    rs1_data_o = '0;
    rs2_data_o = '0;
    if (rs1_i != '0) begin
      rs1_data_o = regs[rs1_i];
    end
    if (rs2_i != '0) begin
      rs2_data_o = regs[rs2_i];
    end
  end

  // ====================
  // Retire port, one cycle after the write
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      retire_o <= '0;
    end else begin
      retire_o <= res_i;
    end
  end

endmodule : reg_writeback

/* verilog/pipeline.sv */
/*
 * Integer pipeline slice, top level.
 * Instruction slot, decode, execute and write-back in order,
 * fed by a four-phase instruction port, with one retire per op.
 */
`timescale 1ns/100ps

module pipeline (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     inst_req_i,
  input  logic [31:0]              inst_i,
  output logic                     inst_ack_o,
  output pipe_stage_pkg::result_st retire_o
);

  pipe_stage_pkg::slot_st        slot;
  pipe_stage_pkg::decoded_st     dec;
  pipe_stage_pkg::result_st      exe_res;
  pipe_isa_pkg::reg_idx_t        rs1;
  pipe_isa_pkg::reg_idx_t        rs2;
  logic [pipe_isa_pkg::XLEN-1:0] rs1_data;
  logic [pipe_isa_pkg::XLEN-1:0] rs2_data;

  inst_accept u_inst_accept (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .inst_req_i (inst_req_i),
    .inst_i     (inst_i),
    .inst_ack_o (inst_ack_o),
    .slot_o     (slot)
  );

  // Decode forwards from the execute result register
  inst_decoder u_inst_decoder (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .slot_i     (slot),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .fwd_i      (exe_res),
    .dec_o      (dec)
  );

  int_execute u_int_execute (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .dec_i   (dec),
    .res_o   (exe_res)
  );

  reg_writeback u_reg_writeback (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .res_i      (exe_res),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .retire_o   (retire_o)
  );

endmodule : pipeline

/* test/pipeline_sva.sv */
/*
 * Protocol and timing checks for the pipeline top level.
 * Four-phase ack rules on the instruction port, one retire per
 * accepted word at a fixed latency, and quiet outputs in reset.
 */
`timescale 1ns/100ps

module pipeline_sva (
  input logic                     clk,
  input logic                     rst_n_i,
  input logic                     inst_req_i,
  input logic                     inst_ack_o,
  input pipe_stage_pkg::result_st retire_o
);

  logic accept;

  // Accepting edge: req high while ack is still low
  assign accept = inst_req_i && !inst_ack_o;

  ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(inst_ack_o) |-> $past(inst_req_i))
    else $error("inst_ack_o rose although inst_req_i was low");

  ack_fall_needs_no_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    $fell(inst_ack_o) |-> !$past(inst_req_i))
    else $error("inst_ack_o fell although inst_req_i was high");

  retire_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    retire_o.valid |=> !retire_o.valid)
    else $error("retire_o.valid high in two cycles in a row");

  // Valid rises after edge N+3, so it is sampled high at N+4
  retire_after_accept: assert property (@(posedge clk) disable iff (!rst_n_i)
    accept |-> ##4 retire_o.valid)
    else $error("no retire three cycles after an accepting edge");

  retire_has_accept: assert property (@(posedge clk) disable iff (!rst_n_i)
    retire_o.valid |-> $past(accept, 4))
    else $error("retire without an accepting edge three cycles before");

  reset_quiet: assert property (@(posedge clk)
    !rst_n_i |-> (!inst_ack_o && !retire_o.valid))
    else $error("inst_ack_o or retire_o.valid high during reset");

endmodule : pipeline_sva

/* test/pipeline_tb.sv */
/*
 * Testbench for the integer pipeline slice.
 * Four-phase instruction source with a register model that queues
 * the expected retire records, and a retire monitor that checks them.
 */
`timescale 1ns/100ps

module pipeline_tb;

  localparam int WAIT_LIMIT = 40;

  logic                     clk;
  logic                     rst_n_i;
  logic                     inst_req_i;
  logic [31:0]              inst_i;
  logic                     inst_ack_o;
  pipe_stage_pkg::result_st retire_o;

  logic [31:0]              model_regs [32];
  pipe_stage_pkg::result_st exp_q [$];

  pipeline u_pipeline (.*);

  bind pipeline pipeline_sva u_pipeline_sva (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // ====================
  // Encoding and reference model
  function automatic logic [31:0] encode(input pipe_isa_pkg::opcode_e op,
      input logic [4:0] rd, input logic [4:0] rj, input logic [4:0] rk, input logic [19:0] imm);
    case (op)
      pipe_isa_pkg::OP_ADD_W:   return {pipe_isa_pkg::OPC_ADD_W, rk, rj, rd};
      pipe_isa_pkg::OP_SUB_W:   return {pipe_isa_pkg::OPC_SUB_W, rk, rj, rd};
      pipe_isa_pkg::OP_AND:     return {pipe_isa_pkg::OPC_AND, rk, rj, rd};
      pipe_isa_pkg::OP_OR:      return {pipe_isa_pkg::OPC_OR, rk, rj, rd};
      pipe_isa_pkg::OP_XOR:     return {pipe_isa_pkg::OPC_XOR, rk, rj, rd};
      pipe_isa_pkg::OP_SLL_W:   return {pipe_isa_pkg::OPC_SLL_W, rk, rj, rd};
      pipe_isa_pkg::OP_SRL_W:   return {pipe_isa_pkg::OPC_SRL_W, rk, rj, rd};
      pipe_isa_pkg::OP_SLT:     return {pipe_isa_pkg::OPC_SLT, rk, rj, rd};
      pipe_isa_pkg::OP_ADDI_W:  return {pipe_isa_pkg::OPC_ADDI_W, imm[11:0], rj, rd};
      pipe_isa_pkg::OP_LU12I_W: return {pipe_isa_pkg::OPC_LU12I_W, imm, rd};
      // All-ones top bits match no major opcode
      default:                  return {12'hFFF, imm[14:0], rd};
    endcase
  endfunction

  function automatic logic [31:0] model_value(input pipe_isa_pkg::opcode_e op,
      input logic [31:0] a, input logic [31:0] b);
    case (op)
      pipe_isa_pkg::OP_ADD_W,
      pipe_isa_pkg::OP_ADDI_W:  return a + b;
      pipe_isa_pkg::OP_SUB_W:   return a - b;
      pipe_isa_pkg::OP_AND:     return a & b;
      pipe_isa_pkg::OP_OR:      return a | b;
      pipe_isa_pkg::OP_XOR:     return a ^ b;
      pipe_isa_pkg::OP_SLL_W:   return a << b[4:0];
      pipe_isa_pkg::OP_SRL_W:   return a >> b[4:0];
      // With mixed signs the negative operand is the smaller one
      pipe_isa_pkg::OP_SLT:     return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      pipe_isa_pkg::OP_LU12I_W: return b;
      default:                  return 32'd0;
    endcase
  endfunction

  // One four-phase transfer that queues the expected retire at the ack
  task automatic send_inst(input pipe_isa_pkg::opcode_e op, input logic [4:0] rd,
      input logic [4:0] rj, input logic [4:0] rk, input logic [19:0] imm);
    pipe_stage_pkg::result_st exp;
    logic [31:0]              opnd_b;
    int                       waited;
    case (op)
      pipe_isa_pkg::OP_ADDI_W:  opnd_b = {{20{imm[11]}}, imm[11:0]};
      pipe_isa_pkg::OP_LU12I_W: opnd_b = {imm, 12'h000};
      default:                  opnd_b = model_regs[rk];
    endcase
    exp.valid = 1'b1;
    exp.rd = rd;
    exp.value = model_value(op, model_regs[rj], opnd_b);
    exp.we = (rd != 5'd0) && (op != pipe_isa_pkg::OP_INVALID);
    inst_i = encode(op, rd, rj, rk, imm);
    inst_req_i = 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timeout: inst_ack_o never rose after inst_req_i");
        abort_run();
      end
    end while (!inst_ack_o);
    exp_q.push_back(exp);
    if (exp.we) begin
      model_regs[rd] = exp.value;
    end
    inst_req_i = 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timeout: inst_ack_o never fell after inst_req_i dropped");
        abort_run();
      end
    end while (inst_ack_o);
  endtask

  // ====================
  // Retire monitor
  initial begin
    pipe_stage_pkg::result_st exp;
    forever begin
      @(negedge clk);
      if (rst_n_i && retire_o.valid) begin
        assert (exp_q.size() > 0) else begin
          $display("Retire seen with no instruction outstanding");
          abort_run();
        end
        exp = exp_q.pop_front();
        assert (retire_o.rd == exp.rd) else begin
          $display("FAILED retire_o.rd: got 0x%02h, expected 0x%02h", retire_o.rd, exp.rd);
          abort_run();
        end
        assert (retire_o.value == exp.value) else begin
          $display("FAILED retire_o.value: got 0x%08h, expected 0x%08h",
                   retire_o.value, exp.value);
          abort_run();
        end
        assert (retire_o.we == exp.we) else begin
          $display("FAILED retire_o.we: got 0x%0h, expected 0x%0h", retire_o.we, exp.we);
          abort_run();
        end
      end
    end
  end

  // ====================
  // Stimulus
  initial begin
    pipe_isa_pkg::opcode_e op;
    int                    waited;
    void'($urandom(30));
    rst_n_i = 1'b0;
    inst_req_i = 1'b0;
    inst_i = 32'd0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end
    repeat (5) begin
      @(negedge clk);
      assert (!inst_ack_o && !retire_o.valid) else begin
        $display("inst_ack_o or retire_o.valid went high during reset");
        abort_run();
      end
    end
    rst_n_i = 1'b1;
    @(negedge clk);

    // Every register reads zero after reset
    for (int k = 0; k < 32; k++) begin
      send_inst(pipe_isa_pkg::OP_ADD_W, 5'(k), 5'(k), 5'd0, 20'd0);
    end

    // Signed compares, masked shift amounts, negative immediates
    send_inst(pipe_isa_pkg::OP_LU12I_W, 5'd1, 5'd0, 5'd0, 20'h80000);
    send_inst(pipe_isa_pkg::OP_ADDI_W, 5'd2, 5'd0, 5'd0, 20'h00FFF);
    send_inst(pipe_isa_pkg::OP_ADDI_W, 5'd3, 5'd0, 5'd0, 20'h00005);
    send_inst(pipe_isa_pkg::OP_SLT, 5'd4, 5'd2, 5'd3, 20'd0);
    send_inst(pipe_isa_pkg::OP_SLT, 5'd5, 5'd3, 5'd2, 20'd0);
    send_inst(pipe_isa_pkg::OP_SLT, 5'd6, 5'd1, 5'd2, 20'd0);
    send_inst(pipe_isa_pkg::OP_ADDI_W, 5'd7, 5'd0, 5'd0, 20'h00021);
    send_inst(pipe_isa_pkg::OP_SLL_W, 5'd8, 5'd3, 5'd7, 20'd0);
    send_inst(pipe_isa_pkg::OP_SRL_W, 5'd9, 5'd2, 5'd7, 20'd0);
    send_inst(pipe_isa_pkg::OP_ADD_W, 5'd10, 5'd1, 5'd2, 20'd0);
    send_inst(pipe_isa_pkg::OP_SUB_W, 5'd11, 5'd3, 5'd2, 20'd0);
    send_inst(pipe_isa_pkg::OP_AND, 5'd12, 5'd2, 5'd3, 20'd0);
    send_inst(pipe_isa_pkg::OP_OR, 5'd13, 5'd1, 5'd3, 20'd0);
    send_inst(pipe_isa_pkg::OP_XOR, 5'd14, 5'd2, 5'd3, 20'd0);
    // Dependent chain at minimum spacing
    send_inst(pipe_isa_pkg::OP_ADDI_W, 5'd15, 5'd0, 5'd0, 20'h00064);
    send_inst(pipe_isa_pkg::OP_ADDI_W, 5'd15, 5'd15, 5'd0, 20'h00FF9);
    send_inst(pipe_isa_pkg::OP_ADD_W, 5'd16, 5'd15, 5'd15, 20'd0);
    send_inst(pipe_isa_pkg::OP_SUB_W, 5'd17, 5'd16, 5'd15, 20'd0);
    // Write to r0 must not forward and the invalid word must not write r9
    send_inst(pipe_isa_pkg::OP_ADDI_W, 5'd0, 5'd0, 5'd0, 20'h00037);
    send_inst(pipe_isa_pkg::OP_ADD_W, 5'd18, 5'd0, 5'd3, 20'd0);
    send_inst(pipe_isa_pkg::OP_INVALID, 5'd9, 5'd0, 5'd0, 20'h12345);
    send_inst(pipe_isa_pkg::OP_ADD_W, 5'd19, 5'd9, 5'd0, 20'd0);

    // Small register range so random ops often depend on each other
    repeat (60) begin
      op = pipe_isa_pkg::opcode_e'(4'($urandom_range(0, 10)));
      send_inst(op, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                5'($urandom_range(0, 7)), 20'($urandom));
    end

    waited = 0;
    while ((exp_q.size() > 0) && (waited <= WAIT_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Retire port stopped with %0d instructions outstanding", exp_q.size());
      abort_run();
    end
  end

endmodule : pipeline_tb

/* build.f */
verilog/pipe_isa_pkg.sv
verilog/pipe_stage_pkg.sv
verilog/inst_accept.sv
verilog/inst_decoder.sv
verilog/int_execute.sv
verilog/reg_writeback.sv
verilog/pipeline.sv
test/pipeline_sva.sv
test/pipeline_tb.sv

/* Makefile */
# Verilator build and run for the integer pipeline slice

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := pipeline_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
PASS_MSG  := RESULT: PASS

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
